/* hdl/snoopyBus_settings.svh */
`ifndef SNOOPYBUS_SETTINGS_SVH
`define SNOOPYBUS_SETTINGS_SVH

// bus and memory widths
`define ADDRESS_WIDTH 16
`define DATA_WIDTH 32

// one cache controller per processor port
`define NUMBER_OF_CACHES 4
`define NUMBER_OF_LINES 8

// cycles from memory enable to functionComplete
`define MEMORY_LATENCY 3

`endif

/* hdl/snoopyPkg.sv */
package snoopyPkg;

	// command driven by the bus owner and seen by every snooper
	typedef enum logic [2:0] {
		NONE,
		BUS_READ,
		BUS_READ_EXCLUSIVE,
		BUS_INVALIDATE,
		WRITE_BACK
	} Command;

	// MSI line state
	typedef enum logic [1:0] {
		INVALID,
		SHARED,
		MODIFIED
	} LineState;

endpackage : snoopyPkg

/* hdl/busArbiter.sv */
`timescale 1ns/1ps
`include "snoopyBus_settings.svh"

module busArbiter (
	input  logic                           clock,
	input  logic                           reset,
	input  logic [`NUMBER_OF_CACHES - 1:0] busRequest,
	input  logic [`NUMBER_OF_CACHES - 1:0] snoopHit,
	output logic [`NUMBER_OF_CACHES - 1:0] cpuGrants,
	output logic [`NUMBER_OF_CACHES - 1:0] snoopyGrants
);
	localparam int POINTER_WIDTH = $clog2(`NUMBER_OF_CACHES);

	logic [POINTER_WIDTH - 1:0]     pointer;
	logic [POINTER_WIDTH - 1:0]     nextPointer;
	logic [`NUMBER_OF_CACHES - 1:0] nextGrant;
	logic                           holdGrant;

	// grant stays locked until its owner drops busRequest
	assign holdGrant = |(cpuGrants & busRequest);

	// first requester at or after the pointer
	always_comb begin
		int candidate;
		nextGrant   = '0;
		nextPointer = pointer;
		for (int offset = 0; offset < `NUMBER_OF_CACHES; offset++) begin
			candidate = (int'(pointer) + offset) % `NUMBER_OF_CACHES;
			if (busRequest[candidate]) begin
				nextGrant[candidate] = 1'b1;
				nextPointer          = POINTER_WIDTH'((candidate + 1) % `NUMBER_OF_CACHES);
				break;
			end
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			cpuGrants <= '0;
			pointer   <= '0;
		end else if (!holdGrant) begin
			cpuGrants <= nextGrant;
			pointer   <= nextPointer;
		end
	end

	// lowest-index hitter supplies, never the bus owner itself
	always_comb begin
		snoopyGrants = '0;
		for (int i = 0; i < `NUMBER_OF_CACHES; i++) begin
			if (snoopHit[i] && !cpuGrants[i]) begin
				snoopyGrants[i] = 1'b1;
				break;
			end
		end
	end
endmodule : busArbiter

/* hdl/snoopyBus.sv */
`timescale 1ns/1ps
`include "snoopyBus_settings.svh"

module snoopyBus (
	// controller side, master path
	input  logic [`NUMBER_OF_CACHES - 1:0][`ADDRESS_WIDTH - 1:0] addresses,
	input  logic [`NUMBER_OF_CACHES - 1:0][`DATA_WIDTH - 1:0]    dataOuts,
	input  logic [`NUMBER_OF_CACHES - 1:0]                       readsEnabled,
	input  logic [`NUMBER_OF_CACHES - 1:0]                       writesEnabled,
	input  snoopyPkg::Command [`NUMBER_OF_CACHES - 1:0]          commandOuts,
	output logic [`DATA_WIDTH - 1:0]                             dataIn,
	output logic                                                 functionComplete,
	output logic                                                 isInvalidated,
	// controller side, snoop path
	output snoopyPkg::Command                                    commandIn,
	output logic [`ADDRESS_WIDTH - 1:0]                          snoopAddress,
	input  logic [`NUMBER_OF_CACHES - 1:0][`DATA_WIDTH - 1:0]    snoopDataOuts,
	input  logic [`NUMBER_OF_CACHES - 1:0]                       snoopCompletes,
	input  logic [`NUMBER_OF_CACHES - 1:0]                       areInvalidated,
	// arbiter side
	input  logic [`NUMBER_OF_CACHES - 1:0]                       cpuGrants,
	input  logic [`NUMBER_OF_CACHES - 1:0]                       snoopyGrants,
	// memory side
	output logic [`ADDRESS_WIDTH - 1:0]                          ramAddress,
	output logic [`DATA_WIDTH - 1:0]                             ramDataOut,
	output logic                                                 ramReadEnabled,
	output logic                                                 ramWriteEnabled,
	input  logic [`DATA_WIDTH - 1:0]                             ramDataIn,
	input  logic                                                 ramFunctionComplete
);
	logic [`ADDRESS_WIDTH - 1:0] busAddress;
	logic [`DATA_WIDTH - 1:0]    busDataOut;
	logic                        busReadEnabled;
	logic                        busWriteEnabled;
	snoopyPkg::Command           busCommand;

	// granted controller drives the shared lines
	always_comb begin
		busAddress      = '0;
		busDataOut      = '0;
		busReadEnabled  = 1'b0;
		busWriteEnabled = 1'b0;
		busCommand      = snoopyPkg::NONE;
		for (int i = 0; i < `NUMBER_OF_CACHES; i++) begin
			if (cpuGrants[i]) begin
				busAddress      = addresses[i];
				busDataOut      = dataOuts[i];
				busReadEnabled  = readsEnabled[i];
				busWriteEnabled = writesEnabled[i];
				busCommand      = commandOuts[i];
				break;
			end
		end
	end

	// broadcast to snoopers
	assign snoopAddress = busAddress;
	assign commandIn    = busCommand;

	// memory only reads when no cache supplies the word
	assign ramAddress      = busAddress;
	assign ramDataOut      = busDataOut;
	assign ramWriteEnabled = busWriteEnabled;
	assign ramReadEnabled  = busReadEnabled && !(|snoopyGrants);

	// supplier data wins over memory
	always_comb begin
		dataIn           = ramDataIn;
		functionComplete = ramFunctionComplete;
		for (int i = 0; i < `NUMBER_OF_CACHES; i++) begin
			if (snoopyGrants[i]) begin
				dataIn           = snoopDataOuts[i];
				functionComplete = snoopCompletes[i];
				break;
			end
		end
	end

	assign isInvalidated = &areInvalidated;
endmodule : snoopyBus

/* hdl/cacheController.sv */
`timescale 1ns/1ps
`include "snoopyBus_settings.svh"

module cacheController (
	input  logic                        clock,
	input  logic                        reset,
	input  logic                        cpuReq,
	input  logic                        cpuWrite,
	input  logic [`ADDRESS_WIDTH - 1:0] cpuAddress,
	input  logic [`DATA_WIDTH - 1:0]    cpuWriteData,
	output logic [`DATA_WIDTH - 1:0]    cpuReadData,
	output logic                        cpuAck,
	output logic                        busRequest,
	input  logic                        busGrant,
	output logic [`ADDRESS_WIDTH - 1:0] address,
	output logic [`DATA_WIDTH - 1:0]    dataOut,
	output logic                        readEnabled,
	output logic                        writeEnabled,
	output snoopyPkg::Command           commandOut,
	input  logic [`DATA_WIDTH - 1:0]    dataIn,
	input  logic                        functionComplete,
	input  logic                        isInvalidated,
	input  snoopyPkg::Command           commandIn,
	input  logic [`ADDRESS_WIDTH - 1:0] snoopAddress,
	output logic                        snoopHit,
	output logic [`DATA_WIDTH - 1:0]    snoopData,
	output logic                        snoopComplete,
	output logic                        snoopInvalidated
);
	localparam int INDEX_WIDTH = $clog2(`NUMBER_OF_LINES);
	localparam int TAG_WIDTH   = `ADDRESS_WIDTH - INDEX_WIDTH;

	typedef enum logic [2:0] {
		IDLE,
		WAIT_GRANT,
		WRITE_VICTIM,
		FILL,
		FILL_WRITE_BACK,
		UPGRADE
	} MasterState;

	MasterState               state;
	logic [TAG_WIDTH - 1:0]   tags [`NUMBER_OF_LINES];
	logic [`DATA_WIDTH - 1:0] words [`NUMBER_OF_LINES];
	snoopyPkg::LineState      lineStates [`NUMBER_OF_LINES];

	logic [INDEX_WIDTH - 1:0] cpuIndex;
	logic [INDEX_WIDTH - 1:0] snoopIndex;
	logic [TAG_WIDTH - 1:0]   cpuTag;
	logic [TAG_WIDTH - 1:0]   snoopTag;
	logic                     cpuHit;
	logic                     victimDirty;
	logic                     snoopPresent;
	logic                     snoopSupply;
	logic                     snoopKill;

	assign cpuIndex    = cpuAddress[INDEX_WIDTH - 1:0];
	assign cpuTag      = cpuAddress[`ADDRESS_WIDTH - 1:INDEX_WIDTH];
	assign cpuHit      = lineStates[cpuIndex] != snoopyPkg::INVALID && tags[cpuIndex] == cpuTag;
	assign victimDirty = lineStates[cpuIndex] == snoopyPkg::MODIFIED && tags[cpuIndex] != cpuTag;

	// snooper is quiet while this port owns the bus
	assign snoopIndex   = snoopAddress[INDEX_WIDTH - 1:0];
	assign snoopTag     = snoopAddress[`ADDRESS_WIDTH - 1:INDEX_WIDTH];
	assign snoopPresent = !busGrant && lineStates[snoopIndex] != snoopyPkg::INVALID
		&& tags[snoopIndex] == snoopTag;
	assign snoopSupply  = snoopPresent && lineStates[snoopIndex] == snoopyPkg::MODIFIED
		&& (commandIn == snoopyPkg::BUS_READ || commandIn == snoopyPkg::BUS_READ_EXCLUSIVE);
	assign snoopKill    = snoopPresent
		&& (commandIn == snoopyPkg::BUS_READ_EXCLUSIVE || commandIn == snoopyPkg::BUS_INVALIDATE);

	// hold the hit through the completion cycle so the supplier stays selected
	assign snoopHit         = snoopSupply || snoopComplete;
	assign snoopInvalidated = !snoopPresent;

	always_comb begin
		address      = cpuAddress;
		dataOut      = words[cpuIndex];
		readEnabled  = 1'b0;
		writeEnabled = 1'b0;
		commandOut   = snoopyPkg::NONE;
		case (state)
			WRITE_VICTIM: begin
				address      = {tags[cpuIndex], cpuIndex};
				writeEnabled = 1'b1;
				commandOut   = snoopyPkg::WRITE_BACK;
			end
			FILL: begin
				readEnabled = 1'b1;
				if (cpuWrite) begin
					commandOut = snoopyPkg::BUS_READ_EXCLUSIVE;
				end else begin
					commandOut = snoopyPkg::BUS_READ;
				end
			end
			// memory does not snarf, so the filled word goes back to it
			FILL_WRITE_BACK: begin
				writeEnabled = 1'b1;
				commandOut   = snoopyPkg::WRITE_BACK;
			end
			UPGRADE: commandOut = snoopyPkg::BUS_INVALIDATE;
			default: ;
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state         <= IDLE;
			cpuAck        <= 1'b0;
			busRequest    <= 1'b0;
			snoopComplete <= 1'b0;
			for (int line = 0; line < `NUMBER_OF_LINES; line++) begin
				lineStates[line] <= snoopyPkg::INVALID;
			end
		end else begin
			// snoop responder
			snoopComplete <= snoopSupply;
			if (snoopSupply) begin
				snoopData <= words[snoopIndex];
			end
			if (snoopKill) begin
				lineStates[snoopIndex] <= snoopyPkg::INVALID;
			end else if (snoopSupply) begin
				lineStates[snoopIndex] <= snoopyPkg::SHARED;
			end

			// ack falls once the processor lets go
			if (cpuAck && !cpuReq) begin
				cpuAck <= 1'b0;
			end

			case (state)
				IDLE: begin
					if (cpuReq && !cpuAck && !snoopSupply && !snoopKill) begin
						if (cpuHit && !cpuWrite) begin
							cpuReadData <= words[cpuIndex];
							cpuAck      <= 1'b1;
						end else if (cpuHit && lineStates[cpuIndex] == snoopyPkg::MODIFIED) begin
							words[cpuIndex] <= cpuWriteData;
							cpuAck          <= 1'b1;
						end else begin
							busRequest <= 1'b1;
							state      <= WAIT_GRANT;
						end
					end
				end
				// line may have changed by snooping while waiting
				WAIT_GRANT: begin
					if (busGrant) begin
						if (cpuHit && cpuWrite) begin
							state <= UPGRADE;
						end else if (victimDirty) begin
							state <= WRITE_VICTIM;
						end else begin
							state <= FILL;
						end
					end
				end
				WRITE_VICTIM: begin
					if (functionComplete) begin
						state <= FILL;
					end
				end
				FILL: begin
					if (functionComplete) begin
						tags[cpuIndex] <= cpuTag;
						if (cpuWrite) begin
							words[cpuIndex]      <= cpuWriteData;
							lineStates[cpuIndex] <= snoopyPkg::MODIFIED;
							cpuAck               <= 1'b1;
							busRequest           <= 1'b0;
							state                <= IDLE;
						end else begin
							words[cpuIndex]      <= dataIn;
							lineStates[cpuIndex] <= snoopyPkg::SHARED;
							cpuReadData          <= dataIn;
							state                <= FILL_WRITE_BACK;
						end
					end
				end
				FILL_WRITE_BACK: begin
					if (functionComplete) begin
						cpuAck     <= 1'b1;
						busRequest <= 1'b0;
						state      <= IDLE;
					end
				end
				UPGRADE: begin
					if (isInvalidated) begin
						words[cpuIndex]      <= cpuWriteData;
						lineStates[cpuIndex] <= snoopyPkg::MODIFIED;
						cpuAck               <= 1'b1;
						busRequest           <= 1'b0;
						state                <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end
endmodule : cacheController

/* hdl/mainMemory.sv */
`timescale 1ns/1ps
`include "snoopyBus_settings.svh"

module mainMemory (
	input  logic                        clock,
	input  logic [`ADDRESS_WIDTH - 1:0] address,
	input  logic [`DATA_WIDTH - 1:0]    dataOut,
	input  logic                        readEnabled,
	input  logic                        writeEnabled,
	output logic [`DATA_WIDTH - 1:0]    dataIn,
	output logic                        functionComplete
);
	localparam int COUNT_WIDTH = $clog2(`MEMORY_LATENCY + 1);

	logic [`DATA_WIDTH - 1:0] words [2 ** `ADDRESS_WIDTH];
	logic [COUNT_WIDTH - 1:0] count;

	// count enabled cycles, complete once the latency is reached
	always_ff @(posedge clock) begin
		functionComplete <= 1'b0;
		count            <= '0;
		if ((readEnabled || writeEnabled) && !functionComplete) begin
			if (count == COUNT_WIDTH'(`MEMORY_LATENCY - 1)) begin
				functionComplete <= 1'b1;
				if (writeEnabled) begin
					words[address] <= dataOut;
				end else begin
					dataIn <= words[address];
				end
			end else begin
				count <= count + 1'b1;
			end
		end
	end
endmodule : mainMemory

/* hdl/coherentMemorySystem.sv */
`timescale 1ns/1ps
`include "snoopyBus_settings.svh"

module coherentMemorySystem (
	input  logic                                                 clock,
	input  logic                                                 reset,
	input  logic [`NUMBER_OF_CACHES - 1:0]                       cpuReq,
	input  logic [`NUMBER_OF_CACHES - 1:0]                       cpuWrite,
	input  logic [`NUMBER_OF_CACHES - 1:0][`ADDRESS_WIDTH - 1:0] cpuAddress,
	input  logic [`NUMBER_OF_CACHES - 1:0][`DATA_WIDTH - 1:0]    cpuWriteData,
	output logic [`NUMBER_OF_CACHES - 1:0][`DATA_WIDTH - 1:0]    cpuReadData,
	output logic [`NUMBER_OF_CACHES - 1:0]                       cpuAck
);
	// arbitration
	logic [`NUMBER_OF_CACHES - 1:0] busRequest;
	logic [`NUMBER_OF_CACHES - 1:0] snoopHit;
	logic [`NUMBER_OF_CACHES - 1:0] cpuGrants;
	logic [`NUMBER_OF_CACHES - 1:0] snoopyGrants;

	// controller to bus
	logic [`NUMBER_OF_CACHES - 1:0][`ADDRESS_WIDTH - 1:0] addresses;
	logic [`NUMBER_OF_CACHES - 1:0][`DATA_WIDTH - 1:0]    dataOuts;
	logic [`NUMBER_OF_CACHES - 1:0]                       readsEnabled;
	logic [`NUMBER_OF_CACHES - 1:0]                       writesEnabled;
	snoopyPkg::Command [`NUMBER_OF_CACHES - 1:0]          commandOuts;
	logic [`NUMBER_OF_CACHES - 1:0][`DATA_WIDTH - 1:0]    snoopDataOuts;
	logic [`NUMBER_OF_CACHES - 1:0]                       snoopCompletes;
	logic [`NUMBER_OF_CACHES - 1:0]                       areInvalidated;

	// bus broadcast
	logic [`DATA_WIDTH - 1:0]    dataIn;
	logic                        functionComplete;
	logic                        isInvalidated;
	snoopyPkg::Command           commandIn;
	logic [`ADDRESS_WIDTH - 1:0] snoopAddress;

	// memory
	logic [`ADDRESS_WIDTH - 1:0] ramAddress;
	logic [`DATA_WIDTH - 1:0]    ramDataOut;
	logic [`DATA_WIDTH - 1:0]    ramDataIn;
	logic                        ramReadEnabled;
	logic                        ramWriteEnabled;
	logic                        ramFunctionComplete;

	genvar port;
	generate
		for (port = 0; port < `NUMBER_OF_CACHES; port++) begin : g_cache
			cacheController i_cacheController (
				.clock           (clock),
				.reset           (reset),
				.cpuReq          (cpuReq[port]),
				.cpuWrite        (cpuWrite[port]),
				.cpuAddress      (cpuAddress[port]),
				.cpuWriteData    (cpuWriteData[port]),
				.cpuReadData     (cpuReadData[port]),
				.cpuAck          (cpuAck[port]),
				.busRequest      (busRequest[port]),
				.busGrant        (cpuGrants[port]),
				.address         (addresses[port]),
				.dataOut         (dataOuts[port]),
				.readEnabled     (readsEnabled[port]),
				.writeEnabled    (writesEnabled[port]),
				.commandOut      (commandOuts[port]),
				.dataIn          (dataIn),
				.functionComplete(functionComplete),
				.isInvalidated   (isInvalidated),
				.commandIn       (commandIn),
				.snoopAddress    (snoopAddress),
				.snoopHit        (snoopHit[port]),
				.snoopData       (snoopDataOuts[port]),
				.snoopComplete   (snoopCompletes[port]),
				.snoopInvalidated(areInvalidated[port])
			);
		end
	endgenerate

	busArbiter i_busArbiter (
		.clock       (clock),
		.reset       (reset),
		.busRequest  (busRequest),
		.snoopHit    (snoopHit),
		.cpuGrants   (cpuGrants),
		.snoopyGrants(snoopyGrants)
	);

	snoopyBus i_snoopyBus (
		.addresses          (addresses),
		.dataOuts           (dataOuts),
		.readsEnabled       (readsEnabled),
		.writesEnabled      (writesEnabled),
		.commandOuts        (commandOuts),
		.dataIn             (dataIn),
		.functionComplete   (functionComplete),
		.isInvalidated      (isInvalidated),
		.commandIn          (commandIn),
		.snoopAddress       (snoopAddress),
		.snoopDataOuts      (snoopDataOuts),
		.snoopCompletes     (snoopCompletes),
		.areInvalidated     (areInvalidated),
		.cpuGrants          (cpuGrants),
		.snoopyGrants       (snoopyGrants),
		.ramAddress         (ramAddress),
		.ramDataOut         (ramDataOut),
		.ramReadEnabled     (ramReadEnabled),
		.ramWriteEnabled    (ramWriteEnabled),
		.ramDataIn          (ramDataIn),
		.ramFunctionComplete(ramFunctionComplete)
	);

	mainMemory i_mainMemory (
		.clock           (clock),
		.address         (ramAddress),
		.dataOut         (ramDataOut),
		.readEnabled     (ramReadEnabled),
		.writeEnabled    (ramWriteEnabled),
		.dataIn          (ramDataIn),
		.functionComplete(ramFunctionComplete)
	);
endmodule : coherentMemorySystem

/* verification/coherentMemorySystem_assertions.sv */
`timescale 1ns/1ps
`include "snoopyBus_settings.svh"

module coherentMemorySystem_assertions (
	input logic                           clock,
	input logic                           reset,
	input logic [`NUMBER_OF_CACHES - 1:0] cpuReq,
	input logic [`NUMBER_OF_CACHES - 1:0] cpuAck,
	input logic [`NUMBER_OF_CACHES - 1:0] cpuGrants,
	input logic [`NUMBER_OF_CACHES - 1:0] snoopyGrants
);
	int failureCount = 0;

	// one bus owner at a time
	grantOneHot: assert property (@(posedge clock) disable iff (reset) $onehot0(cpuGrants))
		else begin
			$error("cpuGrants %b has more than one bit set", cpuGrants);
			failureCount++;
		end

	// supplier is never the bus owner
	supplierNotOwner: assert property (@(posedge clock) disable iff (reset)
		(snoopyGrants & cpuGrants) == '0)
		else begin
			$error("snoopyGrants %b overlaps cpuGrants %b", snoopyGrants, cpuGrants);
			failureCount++;
		end

	genvar port;
	generate
		for (port = 0; port < `NUMBER_OF_CACHES; port++) begin : g_port
			ackNeedsReq: assert property (@(posedge clock) disable iff (reset)
				$rose(cpuAck[port]) |-> $past(cpuReq[port]))
				else begin
					$error("port %0d raised cpuAck without cpuReq", port);
					failureCount++;
				end

			// four-phase release order
			ackFallsAfterReq: assert property (@(posedge clock) disable iff (reset)
				$fell(cpuAck[port]) |-> !$past(cpuReq[port]))
				else begin
					$error("port %0d dropped cpuAck while cpuReq was high", port);
					failureCount++;
				end
		end
	endgenerate
endmodule : coherentMemorySystem_assertions

bind coherentMemorySystem coherentMemorySystem_assertions i_coherentMemorySystem_assertions (
	.clock       (clock),
	.reset       (reset),
	.cpuReq      (cpuReq),
	.cpuAck      (cpuAck),
	.cpuGrants   (cpuGrants),
	.snoopyGrants(snoopyGrants)
);

/* verification/coherentMemorySystem_tb.sv */
`timescale 1ns/1ps
`include "snoopyBus_settings.svh"

module coherentMemorySystem_tb;
	localparam int PORTS = `NUMBER_OF_CACHES;
	localparam int DRIVE_DELAY = 10;
	localparam int OP_WRITE = 1;
	localparam int OP_PAIRED_WRITE = 2;
	localparam int OP_HIT_READ = 3;

	logic                                     clock;
	logic                                     reset;
	logic [PORTS - 1:0]                       cpuReq;
	logic [PORTS - 1:0]                       cpuWrite;
	logic [PORTS - 1:0][`ADDRESS_WIDTH - 1:0] cpuAddress;
	logic [PORTS - 1:0][`DATA_WIDTH - 1:0]    cpuWriteData;
	logic [PORTS - 1:0][`DATA_WIDTH - 1:0]    cpuReadData;
	logic [PORTS - 1:0]                       cpuAck;

	// one entry per testdata line
	int                          opTests[$];
	int                          opPorts[$];
	int                          opCodes[$];
	logic [`ADDRESS_WIDTH - 1:0] opAddresses[$];
	logic [`DATA_WIDTH - 1:0]    opData[$];
	logic [`DATA_WIDTH - 1:0]    opExpected[$];

	// last value written to each address, in file order
	logic [`DATA_WIDTH - 1:0] lastWritten [int];

	int          errorCount;
	int          testErrors;
	logic [31:0] randomState;

	coherentMemorySystem i_coherentMemorySystem (
		.clock       (clock),
		.reset       (reset),
		.cpuReq      (cpuReq),
		.cpuWrite    (cpuWrite),
		.cpuAddress  (cpuAddress),
		.cpuWriteData(cpuWriteData),
		.cpuReadData (cpuReadData),
		.cpuAck      (cpuAck)
	);

	initial begin
		clock = 1'b0;
		forever #50 clock = ~clock;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] state);
		logic [31:0] x;
		x = state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic loadTestdata();
		int                          fd;
		int                          fields;
		int                          test;
		int                          port;
		int                          op;
		logic [`ADDRESS_WIDTH - 1:0] address;
		logic [`DATA_WIDTH - 1:0]    value;
		logic [`DATA_WIDTH - 1:0]    expected;
		string                       line;
		fd = $fopen("verification/coherentMemorySystem_testdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the testdata file");
			errorCount++;
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			void'($fgets(line, fd));
			// skip blank and comment lines
			if (line.len() > 1 && line.getc(0) != 8'h23) begin
				fields = $sscanf(line, "%d %d %d %h %h %h", test, port, op, address, value,
					expected);
				if (fields == 6) begin
					opTests.push_back(test);
					opPorts.push_back(port);
					opCodes.push_back(op);
					opAddresses.push_back(address);
					opData.push_back(value);
					opExpected.push_back(expected);
				end
			end
		end
		$fclose(fd);
		if (opTests.size() == 0) begin
			$display("no operations were found in the testdata file");
			errorCount++;
		end
	endtask

	task automatic checkResult(input int index, input logic [`DATA_WIDTH - 1:0] readValue,
			input int cycles);
		int address;
		address = int'(opAddresses[index]);
		if (opCodes[index] == OP_WRITE || opCodes[index] == OP_PAIRED_WRITE) begin
			lastWritten[address] = opData[index];
		end else begin
			if (!lastWritten.exists(address)) begin
				$display("test %0d reads address %h before anything was written there",
					opTests[index], opAddresses[index]);
				testErrors++;
			end else if (opExpected[index] != lastWritten[address]) begin
				$display("testdata expects %h at address %h but the last write there was %h",
					opExpected[index], opAddresses[index], lastWritten[address]);
				testErrors++;
			end
			if (readValue !== opExpected[index]) begin
				$display("CHECK FAILED at %0t: test %0d port %0d read %h from %h, expected %h",
					$time, opTests[index], opPorts[index], readValue, opAddresses[index],
					opExpected[index]);
				testErrors++;
			end
			if (opCodes[index] == OP_HIT_READ && cycles != 1) begin
				$display("CHECK FAILED at %0t: test %0d port %0d hit took %0d cycles, expected 1",
					$time, opTests[index], opPorts[index], cycles);
				testErrors++;
			end
		end
	endtask

	// full four-phase handshake on one port
	task automatic runOperation(input int index);
		int                       port;
		int                       cycles;
		logic [`DATA_WIDTH - 1:0] readValue;
		port = opPorts[index];
		@(posedge clock);
		#(DRIVE_DELAY);
		cpuWrite[port]     = opCodes[index] == OP_WRITE || opCodes[index] == OP_PAIRED_WRITE;
		cpuAddress[port]   = opAddresses[index];
		cpuWriteData[port] = opData[index];
		cpuReq[port]       = 1'b1;
		cycles = 0;
		do begin
			@(posedge clock);
			#(DRIVE_DELAY);
			cycles++;
		end while (!cpuAck[port]);
		readValue    = cpuReadData[port];
		cpuReq[port] = 1'b0;
		do begin
			@(posedge clock);
			#(DRIVE_DELAY);
		end while (cpuAck[port]);
		checkResult(index, readValue, cycles);
	endtask

	task automatic watchForHang(input int operations);
		repeat (operations * 60 + 100) @(posedge clock);
		$display("timeout: the run hung with operations still outstanding after %0d cycles",
			operations * 60 + 100);
		$display("TESTBENCH FAILED");
		$finish;
	endtask

	initial begin
		int index;
		int currentTest;
		int opsInTest;
		int testsRun;
		int testsFailed;
		int gap;
		int assertionFailures;
		reset        = 1'b1;
		cpuReq       = '0;
		cpuWrite     = '0;
		cpuAddress   = '0;
		cpuWriteData = '0;
		errorCount   = 0;
		testErrors   = 0;
		testsRun     = 0;
		testsFailed  = 0;
		randomState  = 32'd78;
		loadTestdata();
		fork
			watchForHang(opTests.size());
		join_none
		repeat (4) @(posedge clock);
		#(DRIVE_DELAY);
		reset = 1'b0;

		// nothing requested yet, so nothing may be acknowledged
		repeat (3) begin
			@(posedge clock);
			#(DRIVE_DELAY);
			if (cpuAck != '0) begin
				$display("CHECK FAILED at %0t: test 1 cpuAck is %b with no request", $time, cpuAck);
				testErrors++;
			end
		end

		index = 0;
		while (index < opTests.size()) begin
			currentTest = opTests[index];
			opsInTest   = 0;
			while (index < opTests.size() && opTests[index] == currentTest) begin
				randomState = xorshift(randomState);
				gap = int'(randomState % 4);
				repeat (gap) @(posedge clock);
				// a paired write starts on the same cycle as the next line
				if (opCodes[index] == OP_PAIRED_WRITE && index + 1 < opTests.size()) begin
					fork
						runOperation(index);
						runOperation(index + 1);
					join
					index     += 2;
					opsInTest += 2;
				end else begin
					runOperation(index);
					index++;
					opsInTest++;
				end
			end
			if (testErrors == 0) begin
				$display("test %0d: %0d operations, ok", currentTest, opsInTest);
			end else begin
				$display("test %0d: %0d operations, %0d errors", currentTest, opsInTest, testErrors);
				testsFailed++;
			end
			errorCount += testErrors;
			testErrors = 0;
			testsRun++;
		end

		assertionFailures = i_coherentMemorySystem.i_coherentMemorySystem_assertions.failureCount;
		$display("summary: %0d tests run, %0d failed, %0d errors, %0d assertion failures",
			testsRun, testsFailed, errorCount, assertionFailures);
		if (errorCount == 0 && assertionFailures == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	end
endmodule : coherentMemorySystem_tb

/* verification/coherentMemorySystem_testdata.txt */
# test port op address data expected (test, port and op decimal; the rest hex)
# op 0 read, 1 write, 2 write started with the next line, 3 read that must hit
1 0 1 0100 11111111 00000000
1 0 0 0100 00000000 11111111
1 0 3 0100 00000000 11111111
2 0 1 0200 22222222 00000000
2 1 0 0200 00000000 22222222
2 2 0 0200 00000000 22222222
3 2 1 0300 33333333 00000000
3 0 0 0300 00000000 33333333
3 1 0 0300 00000000 33333333
3 1 1 0300 3333aaaa 00000000
3 0 0 0300 00000000 3333aaaa
4 0 1 0410 44440010 00000000
4 0 1 0418 44440018 00000000
4 3 0 0410 00000000 44440010
5 1 1 0501 55550001 00000000
5 2 1 0509 55550009 00000000
5 3 0 0501 00000000 55550001
5 1 1 0509 5555aa09 00000000
5 3 1 0501 5555bb01 00000000
5 2 0 0509 00000000 5555aa09
5 0 0 0501 00000000 5555bb01
5 1 0 0501 00000000 5555bb01
5 3 0 0509 00000000 5555aa09
6 2 2 0600 66660600 00000000
6 3 1 0608 66660608 00000000
6 0 0 0600 00000000 66660600
6 1 0 0608 00000000 66660608

/* coherentMemorySystem.f */
+incdir+hdl
hdl/snoopyPkg.sv
hdl/busArbiter.sv
hdl/snoopyBus.sv
hdl/cacheController.sv
hdl/mainMemory.sv
hdl/coherentMemorySystem.sv
verification/coherentMemorySystem_assertions.sv
verification/coherentMemorySystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= coherentMemorySystem_tb
FILELIST  ?= coherentMemorySystem.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
RUN_FLAGS ?= +verilator+error+limit+1000

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_FLAGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TESTBENCH PASSED"

clean:
	rm -rf $(BUILD_DIR)
